// ==== logic/lockstep_pkg.sv ====
package lockstep_pkg;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////

  localparam int unsigned DATA_W = 16;

  typedef logic [DATA_W-1:0] data_t;

  // Accumulator operations
  typedef enum logic [1:0] {
    OP_CLEAR = 2'd0,
    OP_ADD   = 2'd1,
    OP_SUB   = 2'd2,
    OP_XOR   = 2'd3
  } op_e;

  ////////////////////////////////////////
  // Bundled command and response
  ////////////////////////////////////////

  // Valid, op and operand
  localparam int unsigned CMD_W = 1 + $bits(op_e) + DATA_W;
  typedef logic [CMD_W-1:0] cmd_t;

  // Valid and accumulator value
  localparam int unsigned RESP_W = 1 + DATA_W;
  typedef logic [RESP_W-1:0] resp_t;

endpackage

// ==== logic/lockstep_ctrl.sv ====
`timescale 1ns/1ps

module lockstep_ctrl #(
  parameter int unsigned LockstepOffset = 3
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  localparam int unsigned CntW = $clog2(LockstepOffset);

  ////////////////////////////////////////
  // Shadow reset sequence
  ////////////////////////////////////////

  // The counter stops at LockstepOffset-1, the set flag follows one
  // cycle later and the compare enable one cycle after that

  logic [CntW-1:0] cnt_d;
  logic [CntW-1:0] cnt_q;
  logic            set_d;
  logic            set_q;
  logic            cmp_en_q;

  assign set_d = (cnt_q == CntW'(LockstepOffset - 1));
  assign cnt_d = set_d ? cnt_q : cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      set_q    <= 1'b0;
      cmp_en_q <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      set_q    <= set_d;
      cmp_en_q <= set_q;
    end
  end

  // Asserted with rst_ni, released on a clock edge
  assign shadow_rst_no = set_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

// ==== logic/lockstep_delay.sv ====
`timescale 1ns/1ps

module lockstep_delay #(
  parameter int unsigned Depth = 3,
  parameter int unsigned Width = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o
);

  // Stage 0 takes the input, the last stage drives the output
  logic [Depth-1:0][Width-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= data_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[Depth-1];

endmodule

// ==== logic/acc_core.sv ====
`timescale 1ns/1ps

module acc_core import lockstep_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  in_valid_i,
  input  op_e   in_op_i,
  input  data_t in_data_i,
  output logic  out_valid_o,
  output data_t acc_o,
  output logic  ovf_o
);

  data_t acc_d;
  data_t acc_q;
  data_t sum;
  data_t diff;
  logic  add_ovf;
  logic  sub_ovf;
  logic  ovf_d;
  logic  ovf_q;
  logic  valid_q;

  ////////////////////////////////////////
  // Arithmetic
  ////////////////////////////////////////

  // Both wrap modulo 2^DATA_W
  assign sum  = acc_q + in_data_i;
  assign diff = acc_q - in_data_i;

  // Signed overflow when the sign of the result cannot be right
  assign add_ovf = (acc_q[DATA_W-1] == in_data_i[DATA_W-1]) &&
                   (sum[DATA_W-1] != acc_q[DATA_W-1]);
  assign sub_ovf = (acc_q[DATA_W-1] != in_data_i[DATA_W-1]) &&
                   (diff[DATA_W-1] != acc_q[DATA_W-1]);

  always_comb begin
    acc_d = acc_q;
    ovf_d = 1'b0;
    if (in_valid_i) begin
      case (in_op_i)
        OP_CLEAR: begin
          acc_d = '0;
        end
        OP_ADD: begin
          acc_d = sum;
          ovf_d = add_ovf;
        end
        OP_SUB: begin
          acc_d = diff;
          ovf_d = sub_ovf;
        end
        OP_XOR: begin
          acc_d = acc_q ^ in_data_i;
        end
        default: begin
          acc_d = acc_q;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // State and response
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q   <= '0;
      valid_q <= 1'b0;
      ovf_q   <= 1'b0;
    end else begin
      acc_q   <= acc_d;
      valid_q <= in_valid_i;
      ovf_q   <= ovf_d;
    end
  end

  // Value holds between strobes, valid and overflow pulse for one cycle
  assign out_valid_o = valid_q;
  assign acc_o       = acc_q;
  assign ovf_o       = ovf_q;

endmodule

// ==== logic/lockstep_cmp.sv ====
`timescale 1ns/1ps

module lockstep_cmp import lockstep_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  cmp_en_i,
  input  resp_t shadow_resp_i,
  input  logic  shadow_ovf_i,
  input  resp_t main_resp_i,
  output logic  alert_major_o,
  output logic  alert_minor_o
);

  resp_t shadow_resp_q;
  logic  shadow_ovf_q;
  logic  resp_mismatch;

  // Shadow outputs take one extra cycle, hence the LockstepOffset+1 on the main side
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_resp_q <= '0;
      shadow_ovf_q  <= 1'b0;
    end else begin
      shadow_resp_q <= shadow_resp_i;
      shadow_ovf_q  <= shadow_ovf_i;
    end
  end

  ////////////////////////////////////////
  // Alerts
  ////////////////////////////////////////

  assign resp_mismatch = (shadow_resp_q != main_resp_i);

  // Major on any difference once the shadow is aligned
  assign alert_major_o = cmp_en_i & resp_mismatch;

  // Minor is the shadow's own overflow
  assign alert_minor_o = shadow_ovf_q;

endmodule

// ==== logic/lockstep_top.sv ====
`timescale 1ns/1ps

module lockstep_top import lockstep_pkg::*; #(
  parameter int unsigned LockstepOffset = 3
) (
  input  logic  clk_i,
  input  logic  rst_ni,

  // Command strobe, seen by the main core in the same cycle
  input  logic  in_valid_i,
  input  op_e   in_op_i,
  input  data_t in_data_i,

  // Main core response
  input  logic  core_valid_i,
  input  data_t core_acc_i,

  output logic  alert_major_o,
  output logic  alert_minor_o
);

  // Main outputs wait one more cycle for the shadow output register
  localparam int unsigned OutputsOffset = LockstepOffset + 1;

  ////////////////////////////////////////
  // Shadow reset and compare enable
  ////////////////////////////////////////

  logic shadow_rst_n;
  logic cmp_en;

  lockstep_ctrl #(
    .LockstepOffset(LockstepOffset)
  ) u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .shadow_rst_no(shadow_rst_n),
    .cmp_en_o     (cmp_en)
  );

  ////////////////////////////////////////
  // Command delay
  ////////////////////////////////////////

  cmd_t  cmd_in;
  cmd_t  cmd_dly;
  logic  shadow_valid;
  op_e   shadow_op;
  data_t shadow_data;

  assign cmd_in = {in_valid_i, in_op_i, in_data_i};

  lockstep_delay #(
    .Depth(LockstepOffset),
    .Width(CMD_W)
  ) u_cmd_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .data_i(cmd_in),
    .data_o(cmd_dly)
  );

  assign shadow_valid = cmd_dly[CMD_W-1];
  assign shadow_op    = op_e'(cmd_dly[CMD_W-2 -: $bits(op_e)]);
  assign shadow_data  = cmd_dly[DATA_W-1:0];

  ////////////////////////////////////////
  // Response delay
  ////////////////////////////////////////

  resp_t main_resp;
  resp_t main_resp_dly;

  assign main_resp = {core_valid_i, core_acc_i};

  lockstep_delay #(
    .Depth(OutputsOffset),
    .Width(RESP_W)
  ) u_resp_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .data_i(main_resp),
    .data_o(main_resp_dly)
  );

  ////////////////////////////////////////
  // Shadow core
  ////////////////////////////////////////

  logic  shadow_out_valid;
  data_t shadow_acc;
  logic  shadow_ovf;
  resp_t shadow_resp;

  acc_core u_shadow (
    .clk_i      (clk_i),
    .rst_ni     (shadow_rst_n),
    .in_valid_i (shadow_valid),
    .in_op_i    (shadow_op),
    .in_data_i  (shadow_data),
    .out_valid_o(shadow_out_valid),
    .acc_o      (shadow_acc),
    .ovf_o      (shadow_ovf)
  );

  assign shadow_resp = {shadow_out_valid, shadow_acc};

  ////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////

  lockstep_cmp u_cmp (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmp_en_i     (cmp_en),
    .shadow_resp_i(shadow_resp),
    .shadow_ovf_i (shadow_ovf),
    .main_resp_i  (main_resp_dly),
    .alert_major_o(alert_major_o),
    .alert_minor_o(alert_minor_o)
  );

endmodule

// ==== sim/tb_lockstep.sv ====
`timescale 1ns/1ps

module tb_lockstep import lockstep_pkg::*;;

  localparam int LockstepOffset = 3;
  localparam int ClkPeriod      = 40;
  localparam int ResetCycles    = 8;
  localparam int SchedLen       = 256;
  localparam int NumTests       = 5;

  logic  clk_i;
  logic  rst_ni;
  logic  in_valid_i;
  op_e   in_op_i;
  data_t in_data_i;
  logic  core_valid_i;
  data_t core_acc_i;
  logic  alert_major_o;
  logic  alert_minor_o;

  // Main core model state and corruption controls
  data_t model_acc;
  data_t flip_mask;
  logic  force_valid;

  // Per-cycle stimulus and expected alerts, indexed by cycle after reset
  logic  cmd_valid [SchedLen];
  op_e   cmd_op    [SchedLen];
  data_t cmd_data  [SchedLen];
  data_t flip      [SchedLen];
  logic  spur      [SchedLen];
  logic  exp_major [SchedLen];
  logic  exp_minor [SchedLen];

  integer seed;
  int     err_count;
  int     tests_run;
  int     tests_failed;

  lockstep_top #(
    .LockstepOffset(LockstepOffset)
  ) dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_op_i      (in_op_i),
    .in_data_i    (in_data_i),
    .core_valid_i (core_valid_i),
    .core_acc_i   (core_acc_i),
    .alert_major_o(alert_major_o),
    .alert_minor_o(alert_minor_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // Reference model of the main core
  ////////////////////////////////////////

  function automatic data_t apply_op(input data_t acc, input op_e op, input data_t operand);
    case (op)
      OP_CLEAR: return '0;
      OP_ADD:   return acc + operand;
      OP_SUB:   return acc - operand;
      default:  return acc ^ operand;
    endcase
  endfunction

  // Overflow when the exact signed result leaves the 16-bit range
  function automatic logic signed_overflow(input data_t acc, input op_e op,
                                           input data_t operand);
    int a;
    int b;
    int r;
    a = $signed(acc);
    b = $signed(operand);
    case (op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      default: r = 0;
    endcase
    return (r > (2 ** (DATA_W - 1)) - 1) || (r < -(2 ** (DATA_W - 1)));
  endfunction

  // Responds one cycle after each strobe, value holds otherwise
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      model_acc    <= '0;
      core_valid_i <= 1'b0;
      core_acc_i   <= '0;
    end else if (in_valid_i) begin
      model_acc    <= apply_op(model_acc, in_op_i, in_data_i);
      core_valid_i <= 1'b1;
      core_acc_i   <= apply_op(model_acc, in_op_i, in_data_i) ^ flip_mask;
    end else begin
      core_valid_i <= force_valid;
      core_acc_i   <= model_acc ^ flip_mask;
    end
  end

  ////////////////////////////////////////
  // Compare and report helpers
  ////////////////////////////////////////

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %0b actual %0b", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("ERR %s expected %04h actual %04h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: failed with %0d errors", name, err_count - errs_before);
      tests_failed++;
    end
  endtask

  task automatic clear_schedule();
    for (int n = 0; n < SchedLen; n++) begin
      cmd_valid[n] = 1'b0;
      cmd_op[n]    = OP_CLEAR;
      cmd_data[n]  = '0;
      flip[n]      = '0;
      spur[n]      = 1'b0;
      exp_major[n] = 1'b0;
      exp_minor[n] = 1'b0;
    end
  endtask

  // Puts a strobe in cycle t and marks the shadow overflow it should raise
  task automatic add_command(input int t, input op_e op, input data_t operand,
                             inout data_t pred);
    cmd_valid[t] = 1'b1;
    cmd_op[t]    = op;
    cmd_data[t]  = operand;
    // Seen in the same cycle as the compare of the main response
    if (signed_overflow(pred, op, operand)) begin
      exp_minor[t + LockstepOffset + 2] = 1'b1;
    end
    pred = apply_op(pred, op, operand);
  endtask

  // Returns just after the edge before cycle 0
  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni      <= 1'b0;
    in_valid_i  <= 1'b0;
    flip_mask   <= '0;
    force_valid <= 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  task automatic run_schedule(input string name, input int ncyc);
    for (int n = 0; n < ncyc; n++) begin
      in_valid_i  <= cmd_valid[n];
      in_op_i     <= cmd_op[n];
      in_data_i   <= cmd_data[n];
      // The model picks these up at the next edge, so they act one cycle on
      flip_mask   <= flip[n + 1];
      force_valid <= spur[n + 1];
      @(negedge clk_i);
      check_bit($sformatf("%s alert_major cycle %0d", name, n), exp_major[n], alert_major_o);
      check_bit($sformatf("%s alert_minor cycle %0d", name, n), exp_minor[n], alert_minor_o);
      @(posedge clk_i);
    end
    in_valid_i  <= 1'b0;
    flip_mask   <= '0;
    force_valid <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_idle_after_reset();
    int errs_before;
    errs_before = err_count;
    clear_schedule();
    apply_reset();
    run_schedule("idle_after_reset", 20);
    report_test("idle_after_reset", errs_before);
  endtask

  task automatic test_lockstep_agreement();
    int          errs_before;
    int          t;
    int          last;
    logic [31:0] rnd;
    data_t       pred;
    errs_before = err_count;
    clear_schedule();
    pred = '0;
    t    = 0;
    last = 0;
    for (int i = 0; i < 60; i++) begin
      rnd = $random(seed);
      add_command(t, op_e'(rnd[1:0]), data_t'($random(seed)), pred);
      last = t;
      rnd  = $random(seed);
      t    = t + 1 + rnd[0];
    end
    apply_reset();
    run_schedule("lockstep_agreement", last + LockstepOffset + 6);
    check_data("lockstep_agreement final accumulator", pred, model_acc);
    report_test("lockstep_agreement", errs_before);
  endtask

  task automatic test_data_mismatch();
    int    errs_before;
    data_t pred;
    errs_before = err_count;
    clear_schedule();
    pred = '0;
    add_command(0, OP_ADD, 16'h1234, pred);
    add_command(3, OP_XOR, 16'h00F0, pred);
    flip[10]      = 16'h0020;
    exp_major[10 + LockstepOffset + 1] = 1'b1;
    apply_reset();
    run_schedule("data_mismatch", 24);
    report_test("data_mismatch", errs_before);
  endtask

  task automatic test_spurious_valid();
    int    errs_before;
    data_t pred;
    errs_before = err_count;
    clear_schedule();
    pred = '0;
    add_command(0, OP_SUB, 16'h0005, pred);
    spur[8] = 1'b1;
    exp_major[8 + LockstepOffset + 1] = 1'b1;
    apply_reset();
    run_schedule("spurious_valid", 20);
    report_test("spurious_valid", errs_before);
  endtask

  task automatic test_overflow_alert();
    int    errs_before;
    data_t pred;
    errs_before = err_count;
    clear_schedule();
    pred = '0;
    add_command(0, OP_CLEAR, 16'h0000, pred);
    add_command(2, OP_ADD, 16'h7FFF, pred);
    add_command(4, OP_ADD, 16'h0001, pred);
    apply_reset();
    run_schedule("overflow_alert", 16);
    report_test("overflow_alert", errs_before);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    in_valid_i   = 1'b0;
    in_op_i      = OP_CLEAR;
    in_data_i    = '0;
    core_valid_i = 1'b0;
    core_acc_i   = '0;
    flip_mask    = '0;
    force_valid  = 1'b0;
    seed         = 32'h3828;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;

    test_idle_after_reset();
    test_lockstep_agreement();
    test_data_mismatch();
    test_spurious_valid();
    test_overflow_alert();

    $display("Tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(NumTests * 300 * ClkPeriod);
    $display("Timeout: the tests did not finish in the expected time");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
logic/lockstep_pkg.sv
logic/lockstep_ctrl.sv
logic/lockstep_delay.sv
logic/acc_core.sv
logic/lockstep_cmp.sv
logic/lockstep_top.sv
sim/tb_lockstep.sv
